/* apb_pkg.sv */
// APB bus word and request types, imported by the timer unit and its testbench
`default_nettype none

package apb_pkg;

   // ************************************************************************
   // bus word
   // ************************************************************************

   localparam int unsigned APB_DATA_WIDTH = 32;

   typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

   // ************************************************************************
   // request from the bridge; the address travels on its own port
   // ************************************************************************

   typedef struct packed {
      logic      sel;      // PSEL
      logic      enable;   // PENABLE, high in the access phase
      logic      write;    // PWRITE
      apb_data_t wdata;    // PWDATA
   } apb_req_t;

endpackage

`default_nettype wire

/* timer_pkg.sv */
// timer register map, configuration word and per-channel structs for the timer RTL
`default_nettype none

package timer_pkg;

   import apb_pkg::*;

   typedef logic [31:0] timer_val_t;   // counter and compare value
   typedef logic [7:0]  presc_t;       // prescaler limit

   // ************************************************************************
   // configuration word, last member is bit 0
   // ************************************************************************

   typedef struct packed {
      logic [15:0] rsvd_hi;      // 31:16, stored and read back
      presc_t      presc_val;    // 15:8, prescaler wraps after presc_val+1
      logic        ref_clk_en;   // 7
      logic        presc_en;     // 6
      logic        one_shot;     // 5
      logic        cmp_clr;      // 4
      logic        iem;          // 3, event input enable
      logic        irq_en;       // 2
      logic        rsvd_rst;     // 1, no function, use the reset strobe
      logic        enable;       // 0
   } timer_cfg_t;

   // register select from address bits 5:3, bit 2 picks the hi channel
   typedef enum logic [2:0] {
      REG_CFG   = 3'd0,   // 0x00 lo, 0x04 hi
      REG_VAL   = 3'd1,   // 0x08 lo, 0x0c hi
      REG_CMP   = 3'd2,   // 0x10 lo, 0x14 hi
      REG_START = 3'd3,   // 0x18 lo, 0x1c hi
      REG_RESET = 3'd4    // 0x20 lo, 0x24 hi
   } timer_reg_e;

   // ************************************************************************
   // per-channel traffic between the register interface and a channel
   // ************************************************************************

   // write strobes, valid for a single cycle
   typedef struct packed {
      logic      cfg_we;
      logic      val_we;
      logic      cmp_we;
      logic      start;
      logic      clear;
      apb_data_t wdata;
   } chan_wr_t;

   // readable state of one channel
   typedef struct packed {
      timer_cfg_t cfg;
      timer_val_t cmp;
      timer_val_t val;
   } chan_stat_t;

endpackage

`default_nettype wire

/* timer_ref_sync.sv */
// brings ref_clk_i into the HCLK domain and emits a one-cycle tick per rising edge
`default_nettype none
`timescale 1ns/10ps

module timer_ref_sync
(
   input  wire logic HCLK,
   input  wire logic HRESETn,
   input  wire logic ref_clk_i,
   input  wire logic stoptimer_i,
   output logic      ref_tick_o
);

   logic ref_sync0_q;   // metastability stage
   logic ref_sync1_q;
   logic ref_sync2_q;   // previous level for edge detection

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         ref_sync0_q <= 1'b0;
         ref_sync1_q <= 1'b0;
         ref_sync2_q <= 1'b0;
      end
      else
      begin
         ref_sync0_q <= ref_clk_i;
         ref_sync1_q <= ref_sync0_q;
         ref_sync2_q <= ref_sync1_q;
      end
   end

   // rising edge, dropped while the timers are frozen
   assign ref_tick_o = ref_sync1_q & ~ref_sync2_q & ~stoptimer_i;

endmodule

`default_nettype wire

/* timer_counter.sv */
// loadable up-counter with compare output, used for both prescaler and timer value
`default_nettype none
`timescale 1ns/10ps

module timer_counter
   import timer_pkg::*;
#(
   parameter type count_t = timer_val_t
)
(
   input  wire logic   HCLK,
   input  wire logic   HRESETn,
   input  wire logic   load_i,       // take load_val_i
   input  wire logic   enable_i,     // count one step
   input  wire logic   clear_i,      // back to zero, wins over everything
   input  wire count_t load_val_i,
   input  wire count_t cmp_val_i,
   output count_t      value_o,
   output logic        match_o
);

   count_t value_q;

   // ************************************************************************
   // counter register, priority clear > load > increment
   // ************************************************************************

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         value_q <= '0;
      end
      else if (clear_i)
      begin
         value_q <= '0;
      end
      else if (load_i)
      begin
         value_q <= load_val_i;
      end
      else if (enable_i)
      begin
         value_q <= value_q + count_t'(1);   // wraps at the top
      end
   end

   assign value_o = value_q;
   assign match_o = (value_q == cmp_val_i);   // plain equality, no enable

endmodule

`default_nettype wire

/* timer_channel.sv */
// one 32-bit timer channel: config and compare registers, prescaler, counter and irq
`default_nettype none
`timescale 1ns/10ps

module timer_channel
   import timer_pkg::*;
(
   input  wire logic     HCLK,
   input  wire logic     HRESETn,
   input  wire chan_wr_t wr_i,          // write strobes from the register interface
   input  wire logic     ref_tick_i,    // synchronized ref clock edge
   input  wire logic     event_i,       // external start level
   input  wire logic     stoptimer_i,   // global freeze
   output chan_stat_t    stat_o,
   output logic          irq_o,
   output logic          busy_o
);

   timer_cfg_t cfg_q;
   timer_cfg_t cfg_d;
   timer_val_t cmp_q;

   timer_val_t cnt_val;
   logic       cnt_eq;        // value equals compare
   logic       match;         // equality while enabled
   logic       start_req;     // strobe or enabled event
   logic       presc_adv;     // prescaler step this cycle
   logic       presc_match;   // prescaler at presc_val
   logic       presc_clear;
   logic       tick;          // count tick of the channel
   logic       cnt_step;      // tick that really increments
   logic       cnt_clear;

   // ************************************************************************
   // configuration and compare registers
   // ************************************************************************

   assign start_req = wr_i.start | (event_i & cfg_q.iem);
   assign match     = cnt_eq & cfg_q.enable;

   always_comb
   begin
      cfg_d = cfg_q;
      if (wr_i.cfg_we)
      begin
         cfg_d = timer_cfg_t'(wr_i.wdata);
      end

      // start wins over the one-shot stop
      if (start_req)
      begin
         cfg_d.enable = 1'b1;
      end
      else if (!wr_i.cfg_we && cfg_q.one_shot && match)
      begin
         cfg_d.enable = 1'b0;   // stop once the target is hit
      end
   end

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         cfg_q <= '0;
         cmp_q <= '0;
      end
      else
      begin
         cfg_q <= cfg_d;
         if (wr_i.cmp_we)
         begin
            cmp_q <= wr_i.wdata;
         end
      end
   end

   // ************************************************************************
   // tick generation
   // ************************************************************************

   always_comb
   begin
      presc_adv = 1'b0;
      tick      = 1'b0;
      if (cfg_q.enable && !stoptimer_i)
      begin
         case ({cfg_q.presc_en, cfg_q.ref_clk_en})
            2'b00: tick = 1'b1;             // every HCLK cycle
            2'b01: tick = ref_tick_i;       // every ref clock edge
            2'b10:
            begin
               presc_adv = 1'b1;
               tick      = presc_match;      // prescaler wrap
            end
            default:
            begin
               presc_adv = ref_tick_i;       // prescaler steps on ref edges
               tick      = ref_tick_i & presc_match;
            end
         endcase
      end
   end

   // the prescaler restarts on its own wrap or on the clear strobe
   assign presc_clear = wr_i.clear | (presc_adv & presc_match);

   // one-shot holds the value at cmp
   assign cnt_step  = tick & ~(cfg_q.one_shot & match);
   assign cnt_clear = wr_i.clear | (cfg_q.cmp_clr & match & cnt_step);

   // ************************************************************************
   // counters
   // ************************************************************************

   timer_counter #(
      .count_t    (presc_t)
   ) presc_i (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .load_i     (1'b0),
      .enable_i   (presc_adv),
      .clear_i    (presc_clear),
      .load_val_i (presc_t'(0)),
      .cmp_val_i  (cfg_q.presc_val),
      .value_o    (),
      .match_o    (presc_match)
   );

   timer_counter #(
      .count_t    (timer_val_t)
   ) count_i (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .load_i     (wr_i.val_we),
      .enable_i   (cnt_step),
      .clear_i    (cnt_clear),
      .load_val_i (wr_i.wdata),
      .cmp_val_i  (cmp_q),
      .value_o    (cnt_val),
      .match_o    (cnt_eq)
   );

   // ************************************************************************
   // status and outputs
   // ************************************************************************

   assign stat_o.cfg = cfg_q;
   assign stat_o.cmp = cmp_q;
   assign stat_o.val = cnt_val;

   assign irq_o  = cnt_eq & cfg_q.irq_en;   // level, held while value sits at cmp
   assign busy_o = cfg_q.enable;

endmodule

`default_nettype wire

/* apb_timer_regif.sv */
// APB slave front end of the timer: decodes writes into channel strobes, muxes reads
`default_nettype none
`timescale 1ns/10ps

module apb_timer_regif
   import apb_pkg::*;
   import timer_pkg::*;
#(
   parameter int unsigned APB_ADDR_WIDTH = 12
)
(
   input  wire logic [APB_ADDR_WIDTH-1:0] paddr_i,
   input  wire apb_req_t                  apb_req_i,
   input  wire chan_stat_t                stat_lo_i,
   input  wire chan_stat_t                stat_hi_i,
   output chan_wr_t                       wr_lo_o,
   output chan_wr_t                       wr_hi_o,
   output apb_data_t                      prdata_o,
   output logic                           pready_o
);

   logic       access;    // access phase
   logic       acc_wr;
   logic       acc_rd;
   logic       sel_hi;    // address bit 2
   timer_reg_e reg_sel;
   chan_wr_t   wr_sel;    // strobes before channel steering
   chan_stat_t stat_sel;

   assign access  = apb_req_i.sel & apb_req_i.enable;
   assign acc_wr  = access & apb_req_i.write;
   assign acc_rd  = access & ~apb_req_i.write;
   assign sel_hi  = paddr_i[2];
   assign reg_sel = timer_reg_e'(paddr_i[5:3]);

   assign pready_o = access;   // no wait states

   // ************************************************************************
   // write decode
   // ************************************************************************

   always_comb
   begin
      wr_sel       = '0;
      wr_sel.wdata = apb_req_i.wdata;
      if (acc_wr)
      begin
         case (reg_sel)
            REG_CFG:   wr_sel.cfg_we = 1'b1;
            REG_VAL:   wr_sel.val_we = 1'b1;
            REG_CMP:   wr_sel.cmp_we = 1'b1;
            REG_START: wr_sel.start  = 1'b1;
            REG_RESET: wr_sel.clear  = 1'b1;
            default:   wr_sel.clear  = 1'b0;   // unmapped, ignored
         endcase
      end
   end

   // steer to one channel; the other sees data but no strobe
   always_comb
   begin
      wr_lo_o       = '0;
      wr_hi_o       = '0;
      wr_lo_o.wdata = apb_req_i.wdata;
      wr_hi_o.wdata = apb_req_i.wdata;
      if (sel_hi)
      begin
         wr_hi_o = wr_sel;
      end
      else
      begin
         wr_lo_o = wr_sel;
      end
   end

   // ************************************************************************
   // read mux
   // ************************************************************************

   assign stat_sel = sel_hi ? stat_hi_i : stat_lo_i;

   always_comb
   begin
      prdata_o = '0;   // strobes and holes read as zero
      if (acc_rd)
      begin
         case (reg_sel)
            REG_CFG: prdata_o = stat_sel.cfg;
            REG_VAL: prdata_o = stat_sel.val;
            REG_CMP: prdata_o = stat_sel.cmp;
            default: prdata_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* apb_timer.sv */
// top of the APB timer unit with two 32-bit channels; instantiate on an APB bridge
`default_nettype none
`timescale 1ns/10ps

module apb_timer
   import apb_pkg::*;
   import timer_pkg::*;
#(
   parameter int unsigned APB_ADDR_WIDTH = 12
)
(
   input  wire logic                      HCLK,
   input  wire logic                      HRESETn,
   input  wire logic [APB_ADDR_WIDTH-1:0] PADDR_i,
   input  wire logic                      PSEL_i,
   input  wire logic                      PENABLE_i,
   input  wire logic                      PWRITE_i,
   input  wire apb_data_t                 PWDATA_i,
   output apb_data_t                      PRDATA_o,
   output logic                           PREADY_o,
   output logic                           PSLVERR_o,
   input  wire logic                      ref_clk_i,
   input  wire logic                      stoptimer_i,
   input  wire logic                      event_lo_i,
   input  wire logic                      event_hi_i,
   output logic                           irq_lo_o,
   output logic                           irq_hi_o,
   output logic                           busy_o
);

   apb_req_t   apb_req;
   chan_wr_t   wr_lo;
   chan_wr_t   wr_hi;
   chan_stat_t stat_lo;
   chan_stat_t stat_hi;
   logic       ref_tick;
   logic       busy_lo;
   logic       busy_hi;

   assign apb_req.sel    = PSEL_i;
   assign apb_req.enable = PENABLE_i;
   assign apb_req.write  = PWRITE_i;
   assign apb_req.wdata  = PWDATA_i;

   assign PSLVERR_o = 1'b0;                 // accesses never fail
   assign busy_o    = busy_lo | busy_hi;

   // ************************************************************************
   // bus side
   // ************************************************************************

   apb_timer_regif #(
      .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
   ) regif_i (
      .paddr_i   (PADDR_i),
      .apb_req_i (apb_req),
      .stat_lo_i (stat_lo),
      .stat_hi_i (stat_hi),
      .wr_lo_o   (wr_lo),
      .wr_hi_o   (wr_hi),
      .prdata_o  (PRDATA_o),
      .pready_o  (PREADY_o)
   );

   timer_ref_sync ref_sync_i (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .ref_clk_i   (ref_clk_i),
      .stoptimer_i (stoptimer_i),
      .ref_tick_o  (ref_tick)
   );

   // ************************************************************************
   // channels
   // ************************************************************************

   timer_channel chan_lo_i (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .wr_i        (wr_lo),
      .ref_tick_i  (ref_tick),
      .event_i     (event_lo_i),
      .stoptimer_i (stoptimer_i),
      .stat_o      (stat_lo),
      .irq_o       (irq_lo_o),
      .busy_o      (busy_lo)
   );

   timer_channel chan_hi_i (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .wr_i        (wr_hi),
      .ref_tick_i  (ref_tick),
      .event_i     (event_hi_i),
      .stoptimer_i (stoptimer_i),
      .stat_o      (stat_hi),
      .irq_o       (irq_hi_o),
      .busy_o      (busy_hi)
   );

endmodule

`default_nettype wire

/* tb_apb_timer.sv */
// self-checking testbench for the APB timer unit that is compiled with the project file list
`default_nettype none
`timescale 1ns/10ps

module tb_apb_timer
   import apb_pkg::*;
   import timer_pkg::*;
();

   localparam int unsigned APB_ADDR_WIDTH = 12;
   localparam int unsigned CLK_PERIOD     = 4;
   localparam logic        CHAN_LO        = 1'b0;
   localparam logic        CHAN_HI        = 1'b1;
   // rough cycle budget of tests 1 to 6
   localparam int unsigned TEST_CYCLES    = 60 + 120 + 70 + 180 + 240 + 60;
   localparam int unsigned WATCHDOG_NS    = (2 * TEST_CYCLES + 100) * CLK_PERIOD;

   logic                      HCLK;
   logic                      HRESETn;
   logic [APB_ADDR_WIDTH-1:0] PADDR_i;
   logic                      PSEL_i;
   logic                      PENABLE_i;
   logic                      PWRITE_i;
   apb_data_t                 PWDATA_i;
   apb_data_t                 PRDATA_o;
   logic                      PREADY_o;
   logic                      PSLVERR_o;
   logic                      ref_clk_i;
   logic                      stoptimer_i;
   logic                      event_lo_i;
   logic                      event_hi_i;
   logic                      irq_lo_o;
   logic                      irq_hi_o;
   logic                      busy_o;

   int unsigned cyc = 0;       // rising edges since time zero
   int unsigned rd_cyc;        // edge count seen by the last read
   int unsigned start_cyc;
   int unsigned clr_cyc;
   int unsigned presc;
   int unsigned n_edges;
   int unsigned rise1;
   int unsigned rise2;
   apb_data_t   rd_data;
   timer_val_t  cmp_v;
   logic        irq_watch = 1'b0;   // enables the irq_lo_o checker
   timer_val_t  watch_cmp;
   int unsigned watch_start;

   apb_timer #(
      .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
   ) dut_i (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .PADDR_i     (PADDR_i),
      .PSEL_i      (PSEL_i),
      .PENABLE_i   (PENABLE_i),
      .PWRITE_i    (PWRITE_i),
      .PWDATA_i    (PWDATA_i),
      .PRDATA_o    (PRDATA_o),
      .PREADY_o    (PREADY_o),
      .PSLVERR_o   (PSLVERR_o),
      .ref_clk_i   (ref_clk_i),
      .stoptimer_i (stoptimer_i),
      .event_lo_i  (event_lo_i),
      .event_hi_i  (event_hi_i),
      .irq_lo_o    (irq_lo_o),
      .irq_hi_o    (irq_hi_o),
      .busy_o      (busy_o)
   );

   initial
   begin
      HCLK = 1'b0;
      forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
   end

   always @(posedge HCLK) cyc <= cyc + 1;

   // ************************************************************************
   // reference model and compare tasks
   // ************************************************************************

   // expected counter value after a number of prescaler input steps
   function automatic timer_val_t ref_timer_value(input int unsigned advances,
      input timer_val_t cmp, input logic cmp_clr, input logic one_shot,
      input presc_t presc_val, input logic presc_en);
      int unsigned ticks;
      ticks = presc_en ? advances / (32'(presc_val) + 32'd1) : advances;
      if (one_shot)
         return (ticks < cmp) ? ticks : cmp;   // parks at cmp
      else if (cmp_clr)
         return ticks % (cmp + 32'd1);
      else
         return ticks;
   endfunction

   function automatic logic [APB_ADDR_WIDTH-1:0] reg_addr(input timer_reg_e sel, input logic hi);
      return {6'd0, sel, hi, 2'b00};
   endfunction

   task automatic fail_run();
      $display("Done: errors found");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   // ************************************************************************
   // bus and pin drivers
   // ************************************************************************

   task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input apb_data_t data);
      @(posedge HCLK);
      #1;
      PADDR_i   = addr;
      PWRITE_i  = 1'b1;
      PWDATA_i  = data;
      PSEL_i    = 1'b1;
      PENABLE_i = 1'b0;
      @(posedge HCLK);
      #1 PENABLE_i = 1'b1;     // access phase taken at the next edge
      @(posedge HCLK);
      #1;
      PSEL_i    = 1'b0;
      PENABLE_i = 1'b0;
      PWRITE_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output apb_data_t data);
      @(posedge HCLK);
      #1;
      PADDR_i   = addr;
      PWRITE_i  = 1'b0;
      PSEL_i    = 1'b1;
      PENABLE_i = 1'b0;
      #1;
      check_bit("PREADY_o", PREADY_o, 1'b0);   // setup phase
      check_word("PRDATA_o", PRDATA_o, '0);
      @(posedge HCLK);
      #1 PENABLE_i = 1'b1;
      #1;
      check_bit("PREADY_o", PREADY_o, 1'b1);
      data   = PRDATA_o;
      rd_cyc = cyc;
      @(posedge HCLK);
      #1;
      PSEL_i    = 1'b0;
      PENABLE_i = 1'b0;
   endtask

   task automatic read_check(input logic [APB_ADDR_WIDTH-1:0] addr, input string name,
      input apb_data_t exp);
      apb_data_t data;
      apb_read(addr, data);
      check_word(name, data, exp);
   endtask

   // slow ref clock with 10 cycles high and 10 low so the sync settles
   task automatic ref_edges(input int unsigned count);
      repeat (count)
      begin
         @(posedge HCLK);
         #1 ref_clk_i = 1'b1;
         repeat (10) @(posedge HCLK);
         #1 ref_clk_i = 1'b0;
         repeat (10) @(posedge HCLK);
      end
   endtask

   task automatic wait_irq_hi_rise(input int unsigned limit, output int unsigned at_cyc);
      logic        prev;
      logic        found;
      int unsigned n;
      prev  = 1'b1;   // a level already high is not a rise
      found = 1'b0;
      n     = 0;
      while (!found)
      begin
         @(posedge HCLK);
         #2;
         found = irq_hi_o & ~prev;
         prev  = irq_hi_o;
         n     = n + 1;
         if (!found && n > limit)
         begin
            $display("irq_hi_o never rose within %0d cycles", limit);
            fail_run();
         end
      end
      at_cyc = cyc;
   endtask

   // irq_lo_o against the model every cycle while watched
   initial
   begin
      forever
      begin
         @(posedge HCLK);
         #2;
         if (irq_watch)
            check_bit("irq_lo_o", irq_lo_o, ref_timer_value(cyc - watch_start, watch_cmp,
               1'b1, 1'b0, 8'd0, 1'b0) == watch_cmp);
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the run timed out");
      fail_run();
   end

   // ************************************************************************
   // test sequence
   // ************************************************************************

   initial
   begin
      HRESETn     = 1'b0;
      PADDR_i     = '0;
      PSEL_i      = 1'b0;
      PENABLE_i   = 1'b0;
      PWRITE_i    = 1'b0;
      PWDATA_i    = '0;
      ref_clk_i   = 1'b0;
      stoptimer_i = 1'b0;
      event_lo_i  = 1'b0;
      event_hi_i  = 1'b0;
      void'($urandom(51063));
      #1;
      check_bit("irq_lo_o", irq_lo_o, 1'b0);
      check_bit("irq_hi_o", irq_hi_o, 1'b0);
      check_bit("busy_o", busy_o, 1'b0);
      check_bit("PREADY_o", PREADY_o, 1'b0);
      check_word("PRDATA_o", PRDATA_o, '0);
      repeat (2) @(posedge HCLK);
      #1 HRESETn = 1'b1;

      // test 1 covers readback and the strobe and unmapped offsets
      cmp_v = $urandom;
      apb_write(reg_addr(REG_CFG, CHAN_LO), 32'hA5C3_7EF6);   // enable and iem clear
      apb_write(reg_addr(REG_CMP, CHAN_LO), cmp_v);
      apb_write(reg_addr(REG_CMP, CHAN_HI), ~cmp_v);
      apb_write(reg_addr(REG_VAL, CHAN_LO), 32'h1234_5678);
      read_check(reg_addr(REG_CFG, CHAN_LO), "cfg_lo", 32'hA5C3_7EF6);
      read_check(reg_addr(REG_CMP, CHAN_LO), "cmp_lo", cmp_v);
      read_check(reg_addr(REG_CMP, CHAN_HI), "cmp_hi", ~cmp_v);
      read_check(reg_addr(REG_VAL, CHAN_LO), "val_lo", 32'h1234_5678);
      for (int a = 6; a < 16; a++)
         read_check(12'(4 * a), "PRDATA_o", '0);
      apb_write(reg_addr(REG_CFG, CHAN_LO), '0);
      apb_write(reg_addr(REG_VAL, CHAN_LO), '0);

      // test 2 runs free with compare-and-clear
      cmp_v = 3 + $urandom % 14;
      apb_write(reg_addr(REG_CMP, CHAN_LO), cmp_v);
      apb_write(reg_addr(REG_CFG, CHAN_LO), 32'h14);   // irq_en and cmp_clr
      apb_write(reg_addr(REG_START, CHAN_LO), 32'h1);
      start_cyc   = cyc;
      watch_cmp   = cmp_v;
      watch_start = start_cyc;
      irq_watch   = 1'b1;
      repeat (3)
      begin
         repeat ($urandom % 9) @(posedge HCLK);
         apb_read(reg_addr(REG_VAL, CHAN_LO), rd_data);
         check_word("val_lo", rd_data,
            ref_timer_value(rd_cyc - start_cyc, cmp_v, 1'b1, 1'b0, 8'd0, 1'b0));
      end
      repeat (2 * (cmp_v + 1)) @(posedge HCLK);
      irq_watch = 1'b0;
      apb_write(reg_addr(REG_CFG, CHAN_LO), '0);
      apb_write(reg_addr(REG_VAL, CHAN_LO), '0);

      // test 3 stops the one-shot at cmp and restarts it by the start strobe
      cmp_v = 4 + $urandom % 8;
      apb_write(reg_addr(REG_CMP, CHAN_LO), cmp_v);
      apb_write(reg_addr(REG_CFG, CHAN_LO), 32'h24);   // irq_en and one_shot
      apb_write(reg_addr(REG_START, CHAN_LO), 32'h1);
      start_cyc = cyc;
      #1 check_bit("busy_o", busy_o, 1'b1);
      repeat (cmp_v + 4) @(posedge HCLK);
      apb_read(reg_addr(REG_VAL, CHAN_LO), rd_data);
      check_word("val_lo", rd_data,
         ref_timer_value(rd_cyc - start_cyc, cmp_v, 1'b0, 1'b1, 8'd0, 1'b0));
      #1;
      check_bit("irq_lo_o", irq_lo_o, 1'b1);
      check_bit("busy_o", busy_o, 1'b0);
      apb_write(reg_addr(REG_VAL, CHAN_LO), '0);
      apb_write(reg_addr(REG_START, CHAN_LO), 32'h1);
      start_cyc = cyc;
      #1 check_bit("busy_o", busy_o, 1'b1);
      apb_read(reg_addr(REG_VAL, CHAN_LO), rd_data);
      check_word("val_lo", rd_data,
         ref_timer_value(rd_cyc - start_cyc, cmp_v, 1'b0, 1'b1, 8'd0, 1'b0));
      apb_write(reg_addr(REG_CFG, CHAN_LO), '0);
      apb_write(reg_addr(REG_VAL, CHAN_LO), '0);

      // test 4 runs the prescaler on hi while lo stays idle
      presc = 1 + $urandom % 6;
      cmp_v = 2 + $urandom % 5;
      apb_write(reg_addr(REG_CMP, CHAN_HI), cmp_v);
      apb_write(reg_addr(REG_CFG, CHAN_HI), 32'h54 | (presc << 8));   // presc_en cmp_clr irq_en
      apb_write(reg_addr(REG_START, CHAN_HI), 32'h1);
      start_cyc = cyc;
      wait_irq_hi_rise(2 * (presc + 1) * (cmp_v + 1) + 4, rise1);
      wait_irq_hi_rise(2 * (presc + 1) * (cmp_v + 1) + 4, rise2);
      check_word("irq_hi_o period", rise2 - rise1, (presc + 1) * (cmp_v + 1));
      apb_read(reg_addr(REG_VAL, CHAN_HI), rd_data);
      check_word("val_hi", rd_data,
         ref_timer_value(rd_cyc - start_cyc, cmp_v, 1'b1, 1'b0, presc_t'(presc), 1'b1));
      read_check(reg_addr(REG_VAL, CHAN_LO), "val_lo", '0);
      check_bit("irq_lo_o", irq_lo_o, 1'b0);
      apb_write(reg_addr(REG_CFG, CHAN_HI), '0);

      // test 5 covers event start, ref clock ticks and the stoptimer freeze
      apb_write(reg_addr(REG_CMP, CHAN_LO), 32'hFFFF_FFFF);
      apb_write(reg_addr(REG_CFG, CHAN_LO), 32'h88);   // iem and ref_clk_en
      check_bit("busy_o", busy_o, 1'b0);
      @(posedge HCLK);
      #1 event_lo_i = 1'b1;
      @(posedge HCLK);
      #1 event_lo_i = 1'b0;
      #1 check_bit("busy_o", busy_o, 1'b1);
      n_edges = 2 + $urandom % 4;
      ref_edges(n_edges);
      read_check(reg_addr(REG_VAL, CHAN_LO), "val_lo",
         ref_timer_value(n_edges, 32'hFFFF_FFFF, 1'b0, 1'b0, 8'd0, 1'b0));
      @(posedge HCLK);
      #1 stoptimer_i = 1'b1;
      ref_edges(1 + $urandom % 3);
      @(posedge HCLK);
      #1 stoptimer_i = 1'b0;
      read_check(reg_addr(REG_VAL, CHAN_LO), "val_lo",
         ref_timer_value(n_edges, 32'hFFFF_FFFF, 1'b0, 1'b0, 8'd0, 1'b0));
      ref_edges(1);
      read_check(reg_addr(REG_VAL, CHAN_LO), "val_lo",
         ref_timer_value(n_edges + 1, 32'hFFFF_FFFF, 1'b0, 1'b0, 8'd0, 1'b0));
      apb_write(reg_addr(REG_CFG, CHAN_LO), '0);

      // test 6 has the clear strobe restart a running count
      apb_write(reg_addr(REG_VAL, CHAN_LO), '0);
      apb_write(reg_addr(REG_CFG, CHAN_LO), 32'h1);
      start_cyc = cyc;
      repeat (5 + $urandom % 10) @(posedge HCLK);
      apb_read(reg_addr(REG_VAL, CHAN_LO), rd_data);
      check_word("val_lo", rd_data,
         ref_timer_value(rd_cyc - start_cyc, 32'hFFFF_FFFF, 1'b0, 1'b0, 8'd0, 1'b0));
      apb_write(reg_addr(REG_RESET, CHAN_LO), 32'h1);
      clr_cyc = cyc;
      apb_read(reg_addr(REG_VAL, CHAN_LO), rd_data);
      check_word("val_lo", rd_data,
         ref_timer_value(rd_cyc - clr_cyc, 32'hFFFF_FFFF, 1'b0, 1'b0, 8'd0, 1'b0));
      apb_write(reg_addr(REG_CFG, CHAN_LO), '0);
      check_bit("PSLVERR_o", PSLVERR_o, 1'b0);

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* apb_timer.f */
apb_pkg.sv
timer_pkg.sv
timer_ref_sync.sv
timer_counter.sv
timer_channel.sv
apb_timer_regif.sv
apb_timer.sv
tb_apb_timer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the timer testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
   --top-module tb_apb_timer \
   -f apb_timer.f \
   --Mdir obj_dir -o tb_apb_timer

# a failing run stops with a nonzero status, keep its output anyway
sim_out=$(./obj_dir/tb_apb_timer 2>&1) || true
echo "$sim_out"

if grep -qx "Done: no errors" <<< "$sim_out"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
